// ==== logic/dmaRegPkg.sv ====
package dmaRegPkg;

	// one byte of the cpu data bus
	typedef logic [7:0] dataByte_t;

	// register address lines A3..A0
	typedef logic [3:0] regAddr_t;

	// cpu side of the bus, strobes are active low
	typedef struct packed {
		logic      csN;
		logic      iorN;
		logic      iowN;
		regAddr_t  address;
		dataByte_t data;
	} cpuBus_t;

	// command byte, only disable and priority type are acted on
	// reserved bits are stored as written
	typedef struct packed {
		logic [2:0] reservedHigh;
		logic       rotatingPriority;
		logic       reservedMid;
		logic       controllerDisable;
		logic [1:0] reservedLow;
	} commandReg_t;

	// 16-bit address or count word
	// full view for stepping, byte view for the byte pointer and the bus
	typedef union packed {
		logic [15:0] full;
		struct packed {
			dataByte_t upper;
			dataByte_t lower;
		} bytes;
	} addressWord_u;

	// register map outside the channel block
	localparam regAddr_t commandAddr = 4'd8;
	localparam regAddr_t clearPointerAddr = 4'd12;

	// bit positions inside the command byte
	localparam int rotatingBit = 4;
	localparam int disableBit = 2;

endpackage

// ==== logic/dmaCyclePkg.sv ====
package dmaCyclePkg;

	localparam int numChannels = 4;

	// channel index and one-bit-per-channel mask
	typedef logic [$clog2(numChannels)-1:0] channel_t;
	typedef logic [numChannels-1:0] channelMask_t;

	// one-hot transfer cycle states
	// S3 is not used since every transfer is a single cycle
	typedef enum logic [4:0] {
		SI = 5'b00001,
		SO = 5'b00010,
		S1 = 5'b00100,
		S2 = 5'b01000,
		S4 = 5'b10000
	} cycleState_t;

	// strobes of the running cycle and the channel it serves
	typedef struct packed {
		logic         aen;
		logic         adstb;
		channelMask_t dack;
		logic         serviceDone;
		channel_t     channel;
	} cycleCtl_t;

	// element 0 holds the highest priority channel
	localparam channel_t [numChannels-1:0] resetPriorityOrder = {
		channel_t'(3),
		channel_t'(2),
		channel_t'(1),
		channel_t'(0)
	};

endpackage

// ==== logic/dmaRegisterFile.sv ====
`timescale 1ns/1ps

module dmaRegisterFile (
	input  logic                   busIf,
	input  logic                   reset,
	input  dmaRegPkg::cpuBus_t     cpu,
	input  dmaCyclePkg::cycleCtl_t cycle,
	output dmaRegPkg::commandReg_t command,
	output dmaRegPkg::dataByte_t   addressLow,
	output dmaRegPkg::dataByte_t   dataOut,
	output logic                   dataOutEnable
);
	import dmaRegPkg::*;
	import dmaCyclePkg::*;

	// per channel address and word count, base and current copies
	addressWord_u baseAddress [numChannels];
	addressWord_u currentAddress [numChannels];
	addressWord_u baseCount [numChannels];
	addressWord_u currentCount [numChannels];

	// byte pointer, low selects the lower byte
	logic bytePointer;

	logic writeStrobe;
	logic readStrobe;
	logic channelAccess;
	logic countSelect;
	channel_t cpuChannel;
	addressWord_u writeWord;
	addressWord_u readWord;
	dataByte_t readByte;
	addressWord_u cycleAddress;

	// cpu strobes qualified by chip select
	assign writeStrobe = !cpu.csN && !cpu.iowN;
	assign readStrobe = !cpu.csN && !cpu.iorN;

	// addresses 0..7 hit the channel registers
	// A2..A1 pick the channel, A0 picks address or count
	assign channelAccess = !cpu.address[3];
	assign cpuChannel = cpu.address[2:1];
	assign countSelect = cpu.address[0];

	// new byte merged into the base word, then copied to both registers
	always_comb
	begin
		writeWord = countSelect ? baseCount[cpuChannel] : baseAddress[cpuChannel];
		if (bytePointer)
			writeWord.bytes.upper = cpu.data;
		else
			writeWord.bytes.lower = cpu.data;
	end

	always_ff @(posedge busIf)
	begin
		if (reset)
		begin
			for (int i = 0; i < numChannels; i++)
			begin
				baseAddress[i] <= '0;
				currentAddress[i] <= '0;
				baseCount[i] <= '0;
				currentCount[i] <= '0;
			end
			command <= '0;
			bytePointer <= 1'b0;
		end
		else
		begin
			// end of a transfer, step the served channel
			if (cycle.serviceDone)
			begin
				currentAddress[cycle.channel].full <= currentAddress[cycle.channel].full + 16'd1;
				currentCount[cycle.channel].full <= currentCount[cycle.channel].full - 16'd1;
			end
			// a cpu write to the same channel wins over the step
			if (writeStrobe && channelAccess)
			begin
				if (countSelect)
				begin
					baseCount[cpuChannel] <= writeWord;
					currentCount[cpuChannel] <= writeWord;
				end
				else
				begin
					baseAddress[cpuChannel] <= writeWord;
					currentAddress[cpuChannel] <= writeWord;
				end
			end
			if (writeStrobe && (cpu.address == commandAddr))
				command <= commandReg_t'(cpu.data);
			// pointer flips on every channel access, clear command forces lower byte
			if (writeStrobe && (cpu.address == clearPointerAddr))
				bytePointer <= 1'b0;
			else if ((writeStrobe || readStrobe) && channelAccess)
				bytePointer <= !bytePointer;
		end
	end

	// read back always comes from the current copy
	always_comb
	begin
		readWord = countSelect ? currentCount[cpuChannel] : currentAddress[cpuChannel];
		readByte = bytePointer ? readWord.bytes.upper : readWord.bytes.lower;
	end

	// address of the channel being served
	assign cycleAddress = currentAddress[cycle.channel];

	// lower address byte on the address lines while aen holds the bus
	assign addressLow = cycle.aen ? cycleAddress.bytes.lower : '0;

	// upper address byte rides the data bus during the strobe
	assign dataOut = cycle.adstb ? cycleAddress.bytes.upper : readByte;
	assign dataOutEnable = cycle.adstb || (readStrobe && channelAccess);

endmodule

// ==== logic/dmaPriorityArbiter.sv ====
`timescale 1ns/1ps

module dmaPriorityArbiter (
	input  logic                       busIf,
	input  logic                       reset,
	input  dmaCyclePkg::channelMask_t  dreq,
	input  dmaRegPkg::commandReg_t     command,
	input  dmaCyclePkg::cycleCtl_t     cycle,
	output logic                       requestValid,
	output dmaCyclePkg::channel_t      grantChannel
);
	import dmaCyclePkg::*;

	// order register, element 0 is the highest priority
	channel_t [numChannels-1:0] order;
	// order actually used for the selection
	channel_t [numChannels-1:0] activeOrder;

	// fixed mode ignores any rotation left in the register
	assign activeOrder = command.rotatingPriority ? order : resetPriorityOrder;

	// first requesting channel in priority order
	always_comb
	begin
		requestValid = 1'b0;
		grantChannel = activeOrder[0];
		// walk from lowest to highest so the highest match is the last one kept
		for (int i = numChannels - 1; i >= 0; i--)
		begin
			if (dreq[activeOrder[i]])
			begin
				requestValid = 1'b1;
				grantChannel = activeOrder[i];
			end
		end
	end

	always_ff @(posedge busIf)
	begin
		if (reset)
			order <= resetPriorityOrder;
		else if (!command.rotatingPriority)
			// fixed mode, rotating restarts from channel 0 when enabled
			order <= resetPriorityOrder;
		else if (cycle.serviceDone)
		begin
			// served channel drops to the bottom, its successor goes on top
			for (int i = 0; i < numChannels; i++)
				order[i] <= channel_t'(cycle.channel + channel_t'(i) + 1'b1);
		end
	end

endmodule

// ==== logic/dmaTimingControl.sv ====
`timescale 1ns/1ps

module dmaTimingControl (
	input  logic                   busIf,
	input  logic                   reset,
	input  logic                   requestValid,
	input  dmaCyclePkg::channel_t  grantChannel,
	input  dmaRegPkg::commandReg_t command,
	input  logic                   hlda,
	output logic                   hrq,
	output dmaCyclePkg::cycleCtl_t cycle
);
	import dmaCyclePkg::*;

	cycleState_t state;
	cycleState_t nextState;

	// SI idle, SO waits for hold acknowledge, S1..S4 one cycle each
	always_comb
	begin
		nextState = state;
		case (state)
			SI:
			begin
				// disabled controller never leaves idle
				if (requestValid && !command.controllerDisable)
					nextState = SO;
			end
			SO:
			begin
				// no bound on the hold acknowledge wait
				if (hlda)
					nextState = S1;
			end
			S1:
				nextState = S2;
			S2:
				nextState = S4;
			S4:
				nextState = SI;
			default:
				// illegal one-hot code falls back to idle
				nextState = SI;
		endcase
	end

	// strobes are flopped from the next state so they line up with the state
	always_ff @(posedge busIf)
	begin
		if (reset)
		begin
			state <= SI;
			hrq <= 1'b0;
			cycle <= '0;
		end
		else
		begin
			state <= nextState;
			// hold request from SO through S4
			hrq <= (nextState != SI);
			// address enable over S1 and S2, address strobe in S1 only
			cycle.aen <= (nextState == S1) || (nextState == S2);
			cycle.adstb <= (nextState == S1);
			// acknowledge only the latched channel in S2
			if (nextState == S2)
				cycle.dack <= channelMask_t'(1'b1) << cycle.channel;
			else
				cycle.dack <= '0;
			// one pulse in S4, registers step on the edge that leaves it
			cycle.serviceDone <= (nextState == S4);
			// winner is frozen when the cycle starts
			if ((state == SI) && (nextState == SO))
				cycle.channel <= grantChannel;
		end
	end

endmodule

// ==== logic/dmaController.sv ====
`timescale 1ns/1ps

module dmaController (
	input  logic                      busIf,
	input  logic                      reset,
	input  dmaRegPkg::cpuBus_t        cpu,
	input  dmaCyclePkg::channelMask_t dreq,
	input  logic                      hlda,
	output logic                      hrq,
	output logic                      aen,
	output logic                      adstb,
	output dmaCyclePkg::channelMask_t dack,
	output dmaRegPkg::dataByte_t      addressLow,
	output dmaRegPkg::dataByte_t      dataOut,
	output logic                      dataOutEnable
);
	import dmaRegPkg::*;
	import dmaCyclePkg::*;

	// command bits for priority and disable
	commandReg_t command;
	// strobes and channel of the running cycle
	cycleCtl_t cycle;
	// arbiter result
	logic requestValid;
	channel_t grantChannel;

	// cpu programming, read back and address output
	dmaRegisterFile registerFile (
		.busIf         (busIf),
		.reset         (reset),
		.cpu           (cpu),
		.cycle         (cycle),
		.command       (command),
		.addressLow    (addressLow),
		.dataOut       (dataOut),
		.dataOutEnable (dataOutEnable)
	);

	// picks one of the requesting channels
	dmaPriorityArbiter priorityArbiter (
		.busIf        (busIf),
		.reset        (reset),
		.dreq         (dreq),
		.command      (command),
		.cycle        (cycle),
		.requestValid (requestValid),
		.grantChannel (grantChannel)
	);

	// transfer cycle state machine
	dmaTimingControl timingControl (
		.busIf        (busIf),
		.reset        (reset),
		.requestValid (requestValid),
		.grantChannel (grantChannel),
		.command      (command),
		.hlda         (hlda),
		.hrq          (hrq),
		.cycle        (cycle)
	);

	// bus pins taken from the cycle strobes
	assign aen = cycle.aen;
	assign adstb = cycle.adstb;
	assign dack = cycle.dack;

endmodule

// ==== verification/dmaControllerTb.sv ====
`timescale 1ns/1ps

module dmaControllerTb;
	import dmaRegPkg::*;
	import dmaCyclePkg::*;

	// kinds of table rows
	typedef enum logic [1:0] {
		opWrite,
		opRead,
		opRequest,
		opIdle
	} rowOp_t;

	// one row of stimulus with its expected response
	// expected holds the read byte or the DACK pattern
	// expAddress holds the word shown during ADSTB
	typedef struct packed {
		rowOp_t       op;
		regAddr_t     address;
		dataByte_t    data;
		channelMask_t dreq;
		logic         hlda;
		dataByte_t    expected;
		logic [15:0]  expAddress;
	} stimRow_t;

	logic busIf;
	logic reset;
	cpuBus_t cpu;
	channelMask_t dreq;
	logic hlda;
	logic hrq;
	logic aen;
	logic adstb;
	channelMask_t dack;
	dataByte_t addressLow;
	dataByte_t dataOut;
	logic dataOutEnable;

	stimRow_t rows [$];
	int numRows = 0;
	int cycleLimit;
	int cycleCount;
	int checkCount = 0;
	int errorCount = 0;

	// reference model of the programmed state
	logic [15:0] modelBaseAddr [numChannels];
	logic [15:0] modelCurAddr [numChannels];
	logic [15:0] modelBaseCount [numChannels];
	logic [15:0] modelCurCount [numChannels];
	logic modelPointer;
	logic modelRotating;
	logic modelDisable;
	int modelOrder [numChannels];

	dmaController uut (
		.busIf         (busIf),
		.reset         (reset),
		.cpu           (cpu),
		.dreq          (dreq),
		.hlda          (hlda),
		.hrq           (hrq),
		.aen           (aen),
		.adstb         (adstb),
		.dack          (dack),
		.addressLow    (addressLow),
		.dataOut       (dataOut),
		.dataOutEnable (dataOutEnable)
	);

	// 4 ns clock
	initial
	begin
		busIf = 1'b0;
		forever #2 busIf = ~busIf;
	end

	task automatic checkValue(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		checkCount++;
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("ERROR %s expected %h got %h", name, expected, actual);
		end
	endtask

	// inputs move 1 ns after the rising edge
	task automatic nextCycle();
		@(posedge busIf);
		#1;
	endtask

	task automatic releaseBus();
		cpu.csN = 1'b1;
		cpu.iorN = 1'b1;
		cpu.iowN = 1'b1;
	endtask

	function automatic string opLabel(input rowOp_t op);
		case (op)
			opWrite:
				return "write";
			opRead:
				return "read";
			opRequest:
				return "request";
			default:
				return "idle";
		endcase
	endfunction

	// first requesting channel in the current priority order
	function automatic int pickChannel(input channelMask_t request);
		int order [numChannels];
		for (int i = 0; i < numChannels; i++)
			order[i] = modelRotating ? modelOrder[i] : i;
		for (int i = 0; i < numChannels; i++)
			if (request[order[i]])
				return order[i];
		return -1;
	endfunction

	// append one row while the model predicts its response and moves on
	task automatic addRow(input rowOp_t op, input regAddr_t address, input dataByte_t data,
		input channelMask_t request, input logic grant);
		stimRow_t row;
		int ch;
		logic [15:0] word;
		row.op = op;
		row.address = address;
		row.data = data;
		row.dreq = request;
		row.hlda = grant;
		row.expected = '0;
		row.expAddress = '0;
		ch = address[2:1];
		case (op)
			opWrite:
			begin
				if (address < 4'd8)
				begin
					// new byte lands in the base word and both copies take the result
					word = address[0] ? modelBaseCount[ch] : modelBaseAddr[ch];
					if (modelPointer)
						word[15:8] = data;
					else
						word[7:0] = data;
					if (address[0])
					begin
						modelBaseCount[ch] = word;
						modelCurCount[ch] = word;
					end
					else
					begin
						modelBaseAddr[ch] = word;
						modelCurAddr[ch] = word;
					end
					modelPointer = !modelPointer;
				end
				else if (address == commandAddr)
				begin
					modelRotating = data[rotatingBit];
					modelDisable = data[disableBit];
					if (!modelRotating)
						for (int i = 0; i < numChannels; i++)
							modelOrder[i] = i;
				end
				else if (address == clearPointerAddr)
					modelPointer = 1'b0;
			end
			opRead:
			begin
				word = address[0] ? modelCurCount[ch] : modelCurAddr[ch];
				row.expected = modelPointer ? word[15:8] : word[7:0];
				modelPointer = !modelPointer;
			end
			opRequest:
			begin
				if (grant && !modelDisable)
				begin
					ch = pickChannel(request);
					row.expected = 8'(1 << ch);
					row.expAddress = modelCurAddr[ch];
					modelCurAddr[ch] = modelCurAddr[ch] + 16'd1;
					modelCurCount[ch] = modelCurCount[ch] - 16'd1;
					// served channel goes to the bottom
					if (modelRotating)
						for (int i = 0; i < numChannels; i++)
							modelOrder[i] = (ch + 1 + i) % numChannels;
				end
			end
			default:
			begin
			end
		endcase
		rows.push_back(row);
	endtask

	task automatic readAllRegisters();
		for (int a = 0; a < 8; a++)
		begin
			addRow(opRead, regAddr_t'(a), 8'h00, 4'h0, 1'b0);
			addRow(opRead, regAddr_t'(a), 8'h00, 4'h0, 1'b0);
		end
	endtask

	task automatic buildTable();
		logic [15:0] addrWord;
		logic [15:0] countWord;
		modelPointer = 1'b0;
		modelRotating = 1'b0;
		modelDisable = 1'b0;
		for (int i = 0; i < numChannels; i++)
		begin
			modelBaseAddr[i] = '0;
			modelCurAddr[i] = '0;
			modelBaseCount[i] = '0;
			modelCurCount[i] = '0;
			modelOrder[i] = i;
		end
		// registers read zero after reset
		readAllRegisters();
		// program every channel, lower byte first
		// address low bytes near ff so a step carries
		// count 8000 makes a step borrow
		for (int ch = 0; ch < numChannels; ch++)
		begin
			addrWord = {8'(8'h30 + ch), 8'(8'hfd + ch)};
			countWord = {8'(8'h80 + ch), 8'(8'h22 * ch)};
			addRow(opWrite, regAddr_t'(2 * ch), addrWord[7:0], 4'h0, 1'b0);
			addRow(opWrite, regAddr_t'(2 * ch), addrWord[15:8], 4'h0, 1'b0);
			addRow(opWrite, regAddr_t'(2 * ch + 1), countWord[7:0], 4'h0, 1'b0);
			addRow(opWrite, regAddr_t'(2 * ch + 1), countWord[15:8], 4'h0, 1'b0);
		end
		readAllRegisters();
		// the clear command after an odd access brings back the lower byte
		addRow(opRead, 4'd1, 8'h00, 4'h0, 1'b0);
		addRow(opWrite, clearPointerAddr, 8'h00, 4'h0, 1'b0);
		addRow(opRead, 4'd1, 8'h00, 4'h0, 1'b0);
		addRow(opWrite, clearPointerAddr, 8'h00, 4'h0, 1'b0);
		// fixed priority over every request pattern
		for (int p = 1; p < 16; p++)
			addRow(opRequest, 4'd0, 8'h00, channelMask_t'(p), 1'b1);
		// rotating priority with all requests held
		addRow(opWrite, commandAddr, 8'h10, 4'h0, 1'b0);
		for (int n = 0; n < numChannels; n++)
			addRow(opRequest, 4'd0, 8'h00, 4'hf, 1'b1);
		addRow(opWrite, commandAddr, 8'h00, 4'h0, 1'b0);
		// stepped addresses and counts
		readAllRegisters();
		// disabled controller gets no HLDA since HRQ must stay low
		addRow(opWrite, commandAddr, 8'h04, 4'h0, 1'b0);
		addRow(opRequest, 4'd0, 8'h00, 4'hf, 1'b0);
		addRow(opWrite, commandAddr, 8'h00, 4'h0, 1'b0);
		addRow(opIdle, 4'd0, 8'h00, 4'h0, 1'b0);
	endtask

	task automatic applyRow(input stimRow_t row, input logic keepRequest);
		case (row.op)
			opWrite:
			begin
				nextCycle();
				cpu.csN = 1'b0;
				cpu.iowN = 1'b0;
				cpu.address = row.address;
				cpu.data = row.data;
				nextCycle();
				releaseBus();
			end
			opRead:
			begin
				nextCycle();
				cpu.csN = 1'b0;
				cpu.iorN = 1'b0;
				cpu.address = row.address;
				// read data is combinational and sampled mid cycle
				@(negedge busIf);
				checkValue("dataOut", dataOut, row.expected);
				checkValue("dataOutEnable", dataOutEnable, 1'b1);
				nextCycle();
				releaseBus();
			end
			opRequest:
			begin
				nextCycle();
				dreq = row.dreq;
				hlda = 1'b0;
				if (row.hlda)
				begin
					@(negedge busIf);
					while (!hrq)
						@(negedge busIf);
					nextCycle();
					hlda = 1'b1;
					@(negedge busIf);
					while (!adstb)
					begin
						checkValue("aen", aen, 1'b0);
						@(negedge busIf);
					end
					// S1 carries the address
					checkValue("aen", aen, 1'b1);
					checkValue("dack", dack, 4'h0);
					checkValue("hrq", hrq, 1'b1);
					checkValue("addressLow", addressLow, row.expAddress[7:0]);
					checkValue("dataOut", dataOut, row.expAddress[15:8]);
					checkValue("dataOutEnable", dataOutEnable, 1'b1);
					// S2 acknowledges the channel
					@(negedge busIf);
					checkValue("adstb", adstb, 1'b0);
					checkValue("aen", aen, 1'b1);
					checkValue("dack", dack, row.expected);
					// S4 has the bus strobes off
					@(negedge busIf);
					checkValue("adstb", adstb, 1'b0);
					checkValue("aen", aen, 1'b0);
					checkValue("dack", dack, 4'h0);
					checkValue("hrq", hrq, 1'b1);
				end
				else
				begin
					repeat (20)
					begin
						@(negedge busIf);
						checkValue("hrq", hrq, 1'b0);
					end
				end
				nextCycle();
				hlda = 1'b0;
				if (!keepRequest)
					dreq = '0;
			end
			default:
			begin
				nextCycle();
				@(negedge busIf);
				checkValue("hrq", hrq, 1'b0);
				checkValue("aen", aen, 1'b0);
				checkValue("dataOutEnable", dataOutEnable, 1'b0);
			end
		endcase
	endtask

	// ends a run that stops making progress
	initial
	begin
		wait (numRows > 0);
		cycleLimit = numRows * 24 + 10;
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge busIf);
			cycleCount++;
		end
		$display("timeout after %0d cycles, the DUT stopped responding", cycleCount);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		int errorsBefore;
		logic keepRequest;
		reset = 1'b1;
		cpu = '0;
		releaseBus();
		dreq = '0;
		hlda = 1'b0;
		buildTable();
		numRows = rows.size();
		repeat (5)
			@(posedge busIf);
		#1;
		reset = 1'b0;
		// outputs idle straight out of reset
		@(negedge busIf);
		errorsBefore = errorCount;
		checkValue("hrq", hrq, 1'b0);
		checkValue("aen", aen, 1'b0);
		checkValue("adstb", adstb, 1'b0);
		checkValue("dack", dack, 4'h0);
		checkValue("dataOutEnable", dataOutEnable, 1'b0);
		$display("reset state %s", (errorCount == errorsBefore) ? "ok" : "failed");
		for (int i = 0; i < numRows; i++)
		begin
			errorsBefore = errorCount;
			// same pattern next row keeps DREQ up for back to back cycles
			keepRequest = (i + 1 < numRows) && (rows[i + 1].op == opRequest)
				&& (rows[i + 1].dreq == rows[i].dreq);
			applyRow(rows[i], keepRequest);
			$display("row %0d %s addr %h dreq %h %s", i, opLabel(rows[i].op),
				rows[i].address, rows[i].dreq,
				(errorCount == errorsBefore) ? "ok" : "failed");
		end
		$display("rows %0d, checks %0d, errors %0d", numRows, checkCount, errorCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== list.f ====
logic/dmaRegPkg.sv
logic/dmaCyclePkg.sv
logic/dmaRegisterFile.sv
logic/dmaPriorityArbiter.sv
logic/dmaTimingControl.sv
logic/dmaController.sv
verification/dmaControllerTb.sv

// ==== Bender.yml ====
package:
  name: dmaController

sources:
  - logic/dmaRegPkg.sv
  - logic/dmaCyclePkg.sv
  - logic/dmaRegisterFile.sv
  - logic/dmaPriorityArbiter.sv
  - logic/dmaTimingControl.sv
  - logic/dmaController.sv
  - target: test
    files:
      - verification/dmaControllerTb.sv
